// File: flist.f
hdl/cache_pkg.sv
hdl/cache_way_ram.sv
hdl/cache_array_arbiter.sv
hdl/cache_repl_state.sv
hdl/cache_pipeline.sv
hdl/cache_miss_unit.sv
hdl/cache_top.sv
tb/cache_asserts.sv
tb/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -f flist.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation passed"

// File: tb/cache_tb.sv
// Testbench for the two-way write-back cache.
// Random loads and stores are checked against a flat word model, while a
// DMA memory model answers fills and write-backs after random delays.
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  localparam int sets_c = 16;
  localparam int block_c = 4;
  localparam int mem_words_c = 1024;
  localparam int timeout_c = 2000;
  localparam logic [31:0] pattern_c = 32'h5a5a_0f0f;

  logic clock_i;
  logic reset_i;
  cache_req_t req_i;
  logic v_i;
  logic ready_o;
  logic [word_width_c-1:0] data_o;
  logic v_o;
  logic yumi_i;
  dma_req_t dma_req_o;
  logic dma_req_v_o;
  logic dma_req_yumi_i;
  logic [word_width_c-1:0] dma_read_data_i;
  logic dma_read_v_i;
  logic dma_read_ready_o;
  logic [word_width_c-1:0] dma_write_data_o;
  logic dma_write_v_o;
  logic dma_write_yumi_i;

  logic [31:0] mem [mem_words_c];
  logic [31:0] model [mem_words_c];
  logic written [mem_words_c];
  cache_req_t expect_q [$];

  int seed, yumi_seed, dma_seed;
  int errors, timeouts, sent, received;
  logic backpressure;
  string test_name;

  // DMA memory state
  logic dma_busy, dma_write;
  logic [31:0] dma_line, last_read_addr, last_write_addr;
  int dma_count, read_reqs, write_reqs;

  cache_top #(
    .sets_p(sets_c),
    .block_size_in_words_p(block_c)
  ) uut (.*);

  always #4 clock_i = ~clock_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic send(input logic write, input logic [31:0] addr, input logic [31:0] data);
    int waited;
    cache_req_t req;
    req = '{write: write, addr: addr, data: data};
    req_i = req;
    v_i = 1'b1;
    waited = 0;
    forever begin
      @(negedge clock_i);
      if (ready_o) begin
        expect_q.push_back(req);
        sent++;
        break;
      end
      waited++;
      if (waited == timeout_c) begin
        $display("timeout: request to address %h was never accepted", addr);
        timeouts++;
        break;
      end
      @(posedge clock_i);
      #1;
    end
    @(posedge clock_i);
    #1;
    v_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < timeout_c) begin
      @(posedge clock_i);
      #1;
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("timeout: %0d responses never arrived in %s", expect_q.size(), test_name);
      timeouts++;
    end
  endtask

  // responses come back in request order
  task automatic take_response();
    cache_req_t req;
    int idx;
    received++;
    if (expect_q.size() == 0) begin
      $display("response arrived with no request outstanding in %s", test_name);
      errors++;
      return;
    end
    req = expect_q.pop_front();
    idx = int'(req.addr[11:2]);
    if (req.write) begin
      check_value({test_name, " store response"}, 32'h0, data_o);
      model[idx] = req.data;
      written[idx] = 1'b1;
    end else begin
      check_value({test_name, " load data"}, model[idx], data_o);
    end
  endtask

  // requester side of the response port
  always begin
    @(posedge clock_i);
    #1;
    yumi_i = v_o && (!backpressure || ($random(yumi_seed) & 3) != 0);
    @(negedge clock_i);
    if (v_o && yumi_i) begin
      take_response();
    end
  end

  // memory behind the DMA port serving one request at a time
  always begin
    @(posedge clock_i);
    #1;
    dma_req_yumi_i = dma_req_v_o && !dma_busy && ($random(dma_seed) & 3) == 0;
    dma_read_v_i = dma_busy && !dma_write && ($random(dma_seed) & 1) != 0;
    dma_read_data_i = mem[int'(dma_line[11:2]) + dma_count];
    dma_write_yumi_i = dma_busy && dma_write && dma_write_v_o && ($random(dma_seed) & 1) != 0;
    @(negedge clock_i);
    if (dma_req_v_o && dma_req_yumi_i) begin
      dma_busy = 1'b1;
      dma_write = dma_req_o.write_not_read;
      dma_line = dma_req_o.addr;
      dma_count = 0;
      if (dma_write) begin
        write_reqs++;
        last_write_addr = dma_line;
      end else begin
        read_reqs++;
        last_read_addr = dma_line;
      end
    end
    if (dma_read_v_i && dma_read_ready_o) begin
      dma_count++;
      dma_busy = dma_count != block_c;
    end
    if (dma_write_v_o && dma_write_yumi_i) begin
      check_value({test_name, " write-back word"},
                  model[int'(dma_line[11:2]) + dma_count], dma_write_data_o);
      mem[int'(dma_line[11:2]) + dma_count] = dma_write_data_o;
      dma_count++;
      dma_busy = dma_count != block_c;
    end
  end

  task automatic run_tests();
    int i, reads_before, writes_before;
    logic write_bit;
    logic [31:0] addr, data;

    test_name = "reset";
    @(negedge clock_i);
    check_value("reset ready_o", 32'd1, 32'(ready_o));
    check_value("reset v_o", 32'd0, 32'(v_o));
    check_value("reset dma_req_v_o", 32'd0, 32'(dma_req_v_o));
    check_value("reset dma_write_v_o", 32'd0, 32'(dma_write_v_o));
    check_value("reset dma_read_ready_o", 32'd0, 32'(dma_read_ready_o));
    @(posedge clock_i);
    #1;

    test_name = "cold load";
    reads_before = read_reqs;
    send(1'b0, 32'h44, 32'h0);
    drain();
    if (timeouts != 0) return;
    check_value("cold load read requests", 32'(reads_before + 1), 32'(read_reqs));
    check_value("cold load line address", 32'h40, last_read_addr);

    test_name = "store then load";
    send(1'b1, 32'h84, 32'hcafe_0001);
    send(1'b0, 32'h84, 32'h0);
    drain();
    if (timeouts != 0) return;

    // way 1 filled first, then way 0, so the third line evicts 0x020
    test_name = "eviction";
    writes_before = write_reqs;
    send(1'b1, 32'h024, 32'h1111_0024);
    send(1'b1, 32'h124, 32'h2222_0124);
    send(1'b1, 32'h228, 32'h3333_0228);
    drain();
    if (timeouts != 0) return;
    check_value("eviction write requests", 32'(writes_before + 1), 32'(write_reqs));
    check_value("eviction line address", 32'h020, last_write_addr);

    test_name = "random";
    backpressure = 1'b1;
    for (i = 0; i < 400; i++) begin
      addr = $random(seed) & 32'h7fc;
      write_bit = ($random(seed) & 1) != 0;
      data = $random(seed);
      send(write_bit, addr, data);
      if (timeouts != 0) return;
      if (($random(seed) & 3) == 0) begin
        @(posedge clock_i);
        #1;
      end
    end
    drain();
    if (timeouts != 0) return;

    test_name = "sweep";
    for (i = 0; i < mem_words_c; i++) begin
      if (written[i]) begin
        send(1'b0, 32'(i) << 2, 32'h0);
        if (timeouts != 0) return;
      end
    end
    drain();
    check_value("responses per request", 32'(sent), 32'(received));
  endtask

  task automatic finish_run();
    $display("errors: %0d check, %0d timeout, %0d assertion",
             errors, timeouts, uut.asserts.fail_count);
    if (errors == 0 && timeouts == 0 && uut.asserts.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    seed = 99;
    yumi_seed = seed + 1;
    dma_seed = seed + 2;
    errors = 0;
    timeouts = 0;
    sent = 0;
    received = 0;
    backpressure = 1'b0;
    test_name = "init";
    dma_busy = 1'b0;
    dma_write = 1'b0;
    dma_line = '0;
    dma_count = 0;
    read_reqs = 0;
    write_reqs = 0;
    last_read_addr = '0;
    last_write_addr = '0;
    for (int k = 0; k < mem_words_c; k++) begin
      mem[k] = (32'(k) << 2) ^ pattern_c;
      model[k] = (32'(k) << 2) ^ pattern_c;
      written[k] = 1'b0;
    end
    clock_i = 1'b0;
    reset_i = 1'b1;
    req_i = '0;
    v_i = 1'b0;
    yumi_i = 1'b0;
    dma_req_yumi_i = 1'b0;
    dma_read_data_i = '0;
    dma_read_v_i = 1'b0;
    dma_write_yumi_i = 1'b0;
    repeat (4) @(posedge clock_i);
    #1;
    reset_i = 1'b0;
    run_tests();
    finish_run();
  end

endmodule

`default_nettype wire

// File: tb/cache_asserts.sv
// Handshake rules of the cache top level as concurrent assertions.
// Bound into cache_top; fail_count is read by the testbench at the end.
`timescale 1ns/1ps
`default_nettype none

module cache_asserts
  import cache_pkg::*;
(
  input wire logic                    clock_i,
  input wire logic                    reset_i,
  input wire logic                    v_o,
  input wire logic [word_width_c-1:0] data_o,
  input wire logic                    yumi_i,
  input wire dma_req_t                dma_req_o,
  input wire logic                    dma_req_v_o,
  input wire logic                    dma_req_yumi_i,
  input wire logic                    dma_write_v_o,
  input wire logic                    dma_write_yumi_i
);

  int fail_count = 0;

  response_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o))
  else begin
    $error("response dropped or changed before yumi_i");
    fail_count++;
  end

  dma_req_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    dma_req_v_o && !dma_req_yumi_i |=> dma_req_v_o && $stable(dma_req_o))
  else begin
    $error("DMA request dropped or changed before dma_req_yumi_i");
    fail_count++;
  end

  dma_write_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    dma_write_v_o && !dma_write_yumi_i |=> dma_write_v_o)
  else begin
    $error("DMA write word dropped before dma_write_yumi_i");
    fail_count++;
  end

endmodule

bind cache_top cache_asserts asserts (
  .clock_i(clock_i),
  .reset_i(reset_i),
  .v_o(v_o),
  .data_o(data_o),
  .yumi_i(yumi_i),
  .dma_req_o(dma_req_o),
  .dma_req_v_o(dma_req_v_o),
  .dma_req_yumi_i(dma_req_yumi_i),
  .dma_write_v_o(dma_write_v_o),
  .dma_write_yumi_i(dma_write_yumi_i)
);

`default_nettype wire

// File: hdl/cache_top.sv
// Top level of the two-way write-back data cache.
// One requester port on the front, a word-wide DMA memory port behind.
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int block_size_in_words_p = 4
) (
  input  wire logic                    clock_i,
  input  wire logic                    reset_i,
  input  wire cache_req_t              req_i,
  input  wire logic                    v_i,
  output logic                         ready_o,
  output logic [word_width_c-1:0]      data_o,
  output logic                         v_o,
  input  wire logic                    yumi_i,
  output dma_req_t                     dma_req_o,
  output logic                         dma_req_v_o,
  input  wire logic                    dma_req_yumi_i,
  input  wire logic [word_width_c-1:0] dma_read_data_i,
  input  wire logic                    dma_read_v_i,
  output logic                         dma_read_ready_o,
  output logic [word_width_c-1:0]      dma_write_data_o,
  output logic                         dma_write_v_o,
  input  wire logic                    dma_write_yumi_i
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int offset_width_lp = $clog2(block_size_in_words_p);

  array_req_t pipe_array_req, miss_array_req;
  logic tag_en, data_en, pipe_owns_rdata;
  logic [ways_c-1:0] tag_we, data_we;
  logic [index_width_lp-1:0] tag_addr;
  logic [index_width_lp+offset_width_lp-1:0] data_addr;
  tag_entry_t tag_wdata;
  tag_entry_t [ways_c-1:0] tag_rdata;
  logic [word_width_c-1:0] data_wdata;
  logic [ways_c-1:0][word_width_c-1:0] data_rdata;

  logic miss_start, miss_store, miss_done, victim_way, victim_dirty;
  logic [addr_width_c-1:0] miss_addr;
  logic [word_width_c-1:0] miss_wdata, fill_word;
  logic hit_update, hit_way, hit_store, fill_update, fill_way, fill_dirty;

  cache_pipeline #(
    .sets_p(sets_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) pipeline (
    .clock_i, .reset_i, .req_i, .v_i, .ready_o, .data_o, .v_o, .yumi_i,
    .array_req_o(pipe_array_req),
    .tag_rdata_i(tag_rdata),
    .data_rdata_i(data_rdata),
    .pipe_owns_rdata_i(pipe_owns_rdata),
    .miss_start_o(miss_start),
    .miss_addr_o(miss_addr),
    .miss_store_o(miss_store),
    .miss_wdata_o(miss_wdata),
    .miss_done_i(miss_done),
    .fill_word_i(fill_word),
    .hit_update_o(hit_update),
    .hit_way_o(hit_way),
    .hit_store_o(hit_store)
  );

  cache_miss_unit #(
    .sets_p(sets_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) miss_unit (
    .clock_i, .reset_i,
    .miss_start_i(miss_start),
    .miss_addr_i(miss_addr),
    .miss_store_i(miss_store),
    .miss_wdata_i(miss_wdata),
    .victim_way_i(victim_way),
    .victim_dirty_i(victim_dirty),
    .tag_rdata_i(tag_rdata),
    .data_rdata_i(data_rdata),
    .array_req_o(miss_array_req),
    .dma_req_o, .dma_req_v_o, .dma_req_yumi_i,
    .dma_read_data_i, .dma_read_v_i, .dma_read_ready_o,
    .dma_write_data_o, .dma_write_v_o, .dma_write_yumi_i,
    .fill_update_o(fill_update),
    .fill_way_o(fill_way),
    .fill_dirty_o(fill_dirty),
    .miss_done_o(miss_done),
    .fill_word_o(fill_word)
  );

  // the v-stage address selects the set for both hit and fill updates
  cache_repl_state #(
    .sets_p(sets_p)
  ) repl_state (
    .clock_i, .reset_i,
    .set_i(miss_addr[offset_width_lp+2 +: index_width_lp]),
    .hit_update_i(hit_update),
    .hit_way_i(hit_way),
    .hit_store_i(hit_store),
    .fill_update_i(fill_update),
    .fill_way_i(fill_way),
    .fill_dirty_i(fill_dirty),
    .victim_way_o(victim_way),
    .victim_dirty_o(victim_dirty)
  );

  cache_array_arbiter #(
    .sets_p(sets_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) array_arbiter (
    .clock_i, .reset_i,
    .pipe_req_i(pipe_array_req),
    .miss_req_i(miss_array_req),
    .tag_en_o(tag_en),
    .tag_we_o(tag_we),
    .tag_addr_o(tag_addr),
    .tag_wdata_o(tag_wdata),
    .data_en_o(data_en),
    .data_we_o(data_we),
    .data_addr_o(data_addr),
    .data_wdata_o(data_wdata),
    .pipe_owns_rdata_o(pipe_owns_rdata)
  );

  cache_way_ram #(
    .entry_t(tag_entry_t),
    .depth_p(sets_p)
  ) tag_ram (
    .clock_i,
    .en_i(tag_en),
    .we_i(tag_we),
    .addr_i(tag_addr),
    .wdata_i(tag_wdata),
    .rdata_o(tag_rdata)
  );

  cache_way_ram #(
    .entry_t(logic [word_width_c-1:0]),
    .depth_p(sets_p * block_size_in_words_p)
  ) data_ram (
    .clock_i,
    .en_i(data_en),
    .we_i(data_we),
    .addr_i(data_addr),
    .wdata_i(data_wdata),
    .rdata_o(data_rdata)
  );

endmodule

`default_nettype wire

// File: hdl/cache_miss_unit.sv
// Miss handling: writes back a dirty victim, fills the line over DMA,
// merges a store-miss word, rewrites the tag and returns the missed word.
// Started by a pulse from the pipeline, answers with miss_done_o.
`timescale 1ns/1ps
`default_nettype none

module cache_miss_unit
  import cache_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int block_size_in_words_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int offset_width_lp = $clog2(block_size_in_words_p),
  localparam int low_bits_lp = index_width_lp + offset_width_lp
) (
  input  wire logic                                  clock_i,
  input  wire logic                                  reset_i,
  input  wire logic                                  miss_start_i,
  input  wire logic [addr_width_c-1:0]               miss_addr_i,
  input  wire logic                                  miss_store_i,
  input  wire logic [word_width_c-1:0]               miss_wdata_i,
  input  wire logic                                  victim_way_i,
  input  wire logic                                  victim_dirty_i,
  input  wire tag_entry_t [ways_c-1:0]               tag_rdata_i,
  input  wire logic [ways_c-1:0][word_width_c-1:0]   data_rdata_i,
  output array_req_t                                 array_req_o,
  output dma_req_t                                   dma_req_o,
  output logic                                       dma_req_v_o,
  input  wire logic                                  dma_req_yumi_i,
  input  wire logic [word_width_c-1:0]               dma_read_data_i,
  input  wire logic                                  dma_read_v_i,
  output logic                                       dma_read_ready_o,
  output logic [word_width_c-1:0]                    dma_write_data_o,
  output logic                                       dma_write_v_o,
  input  wire logic                                  dma_write_yumi_i,
  output logic                                       fill_update_o,
  output logic                                       fill_way_o,
  output logic                                       fill_dirty_o,
  output logic                                       miss_done_o,
  output logic [word_width_c-1:0]                    fill_word_o
);

  typedef enum logic [2:0] {
    idle_s,
    evict_req_s,
    evict_stream_s,
    fill_req_s,
    fill_stream_s,
    tag_write_s,
    done_s
  } state_e;

  state_e state_r, state_n;
  logic [offset_width_lp-1:0] cnt_r, miss_offset;
  logic last_word, miss_store_r, victim_way_r;
  logic [addr_width_c-1:0] miss_addr_r, line_addr, evict_addr;
  logic [word_width_c-1:0] miss_wdata_r, fill_word_r, fill_data;
  logic [ways_c-1:0] way_mask;
  tag_entry_t victim_tag, new_tag;

  assign miss_offset = miss_addr_r[2 +: offset_width_lp];
  assign last_word = &cnt_r;
  assign line_addr = {miss_addr_r[addr_width_c-1:offset_width_lp+2], {(offset_width_lp+2){1'b0}}};

  // victim sits in the same set, only its tag bits differ
  assign victim_tag = tag_rdata_i[victim_way_r];
  assign evict_addr = {victim_tag.tag[addr_width_c-3:low_bits_lp], line_addr[low_bits_lp+1:0]};

  assign way_mask = ways_c'(1) << victim_way_r;
  assign fill_data = (miss_store_r && cnt_r == miss_offset) ? miss_wdata_r : dma_read_data_i;
  assign new_tag = '{valid: 1'b1, tag: tag_bits(miss_addr_r, low_bits_lp)};

  always_comb begin
    state_n = state_r;
    case (state_r)
      idle_s:         if (miss_start_i) state_n = victim_dirty_i ? evict_req_s : fill_req_s;
      evict_req_s:    if (dma_req_yumi_i) state_n = evict_stream_s;
      evict_stream_s: if (dma_write_yumi_i && last_word) state_n = fill_req_s;
      fill_req_s:     if (dma_req_yumi_i) state_n = fill_stream_s;
      fill_stream_s:  if (dma_read_v_i && last_word) state_n = tag_write_s;
      tag_write_s:    state_n = done_s;
      default:        state_n = idle_s;
    endcase
  end

  always_comb begin
    array_req_o = '0;
    array_req_o.index[index_width_lp-1:0] = miss_addr_r[offset_width_lp+2 +: index_width_lp];
    array_req_o.offset[offset_width_lp-1:0] = cnt_r;
    array_req_o.tag = new_tag;
    array_req_o.data = fill_data;
    case (state_r)
      idle_s: begin
        // victim tag and word 0 of the set, cnt_r is zero here
        array_req_o.re = miss_start_i;
        array_req_o.index[index_width_lp-1:0] = miss_addr_i[offset_width_lp+2 +: index_width_lp];
      end
      evict_stream_s: begin
        // fetch the next word as the current one is taken
        array_req_o.re = dma_write_yumi_i & ~last_word;
        array_req_o.offset[offset_width_lp-1:0] = cnt_r + 1'b1;
      end
      fill_stream_s: array_req_o.data_we = dma_read_v_i ? way_mask : '0;
      tag_write_s:   array_req_o.tag_we = way_mask;
      default: ;
    endcase
  end

  // cnt_r wraps back to zero at the end of each stream
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= idle_s;
      cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if ((state_r == evict_stream_s && dma_write_yumi_i)
          || (state_r == fill_stream_s && dma_read_v_i)) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (state_r == idle_s && miss_start_i) begin
      miss_addr_r <= miss_addr_i;
      miss_store_r <= miss_store_i;
      miss_wdata_r <= miss_wdata_i;
      victim_way_r <= victim_way_i;
    end
    if (state_r == fill_stream_s && dma_read_v_i && cnt_r == miss_offset) begin
      fill_word_r <= fill_data;
    end
  end

  assign dma_req_v_o = state_r == evict_req_s || state_r == fill_req_s;
  assign dma_req_o.write_not_read = state_r == evict_req_s;
  assign dma_req_o.addr = (state_r == evict_req_s) ? evict_addr : line_addr;
  assign dma_write_v_o = state_r == evict_stream_s;
  assign dma_write_data_o = data_rdata_i[victim_way_r];
  assign dma_read_ready_o = state_r == fill_stream_s;

  assign fill_update_o = state_r == tag_write_s;
  assign fill_way_o = victim_way_r;
  assign fill_dirty_o = miss_store_r;
  assign miss_done_o = state_r == done_s;
  assign fill_word_o = fill_word_r;

endmodule

`default_nettype wire

// File: hdl/cache_pipeline.sv
// Request pipeline of the cache: tag lookup (tl) and verify (v) stages.
// Detects hits, writes store hits, hands misses to the miss unit and
// replays the tl lookup once the fill is done.
`timescale 1ns/1ps
`default_nettype none

module cache_pipeline
  import cache_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int block_size_in_words_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int offset_width_lp = $clog2(block_size_in_words_p)
) (
  input  wire logic                                  clock_i,
  input  wire logic                                  reset_i,
  input  wire cache_req_t                            req_i,
  input  wire logic                                  v_i,
  output logic                                       ready_o,
  output logic [word_width_c-1:0]                    data_o,
  output logic                                       v_o,
  input  wire logic                                  yumi_i,
  output array_req_t                                 array_req_o,
  input  wire tag_entry_t [ways_c-1:0]               tag_rdata_i,
  input  wire logic [ways_c-1:0][word_width_c-1:0]   data_rdata_i,
  input  wire logic                                  pipe_owns_rdata_i,
  output logic                                       miss_start_o,
  output logic [addr_width_c-1:0]                    miss_addr_o,
  output logic                                       miss_store_o,
  output logic [word_width_c-1:0]                    miss_wdata_o,
  input  wire logic                                  miss_done_i,
  input  wire logic [word_width_c-1:0]               fill_word_i,
  output logic                                       hit_update_o,
  output logic                                       hit_way_o,
  output logic                                       hit_store_o
);

  logic tl_v_r;
  cache_req_t tl_req_r;
  tag_entry_t [ways_c-1:0] tl_tags, tl_tags_r;
  logic [ways_c-1:0][word_width_c-1:0] tl_words, tl_words_r;
  logic [ways_c-1:0] hit_ways;
  logic tl_hit, tl_way, tl_moves, store_write;

  logic v_v_r, v_miss_r, v_write_r, v_way_r, v_we;
  logic [addr_width_c-1:0] v_addr_r;
  logic [word_width_c-1:0] v_wdata_r, v_data_r;
  logic miss_start_r, hit_update_r, replay_r;

  // array outputs move under the miss unit, keep a private copy
  assign tl_tags = pipe_owns_rdata_i ? tag_rdata_i : tl_tags_r;
  assign tl_words = pipe_owns_rdata_i ? data_rdata_i : tl_words_r;

  always_comb begin
    for (int w = 0; w < ways_c; w++) begin
      hit_ways[w] = tl_tags[w].valid
        && tl_tags[w].tag == tag_bits(tl_req_r.addr, index_width_lp + offset_width_lp);
    end
  end

  assign tl_hit = |hit_ways;
  assign tl_way = hit_ways[1];

  assign v_o = v_v_r & ~v_miss_r;
  assign v_we = ~v_miss_r & (~v_v_r | yumi_i);
  // tl data is stale during the replay read
  assign tl_moves = tl_v_r & v_we & ~replay_r;
  assign store_write = tl_moves & tl_hit & tl_req_r.write;
  assign ready_o = ~v_miss_r & ~replay_r & ~store_write & (~tl_v_r | tl_moves);

  always_comb begin
    array_req_o = '0;
    if (store_write || replay_r) begin
      array_req_o.re = replay_r & tl_v_r;
      array_req_o.data_we = store_write ? hit_ways : '0;
      array_req_o.index[index_width_lp-1:0] =
        tl_req_r.addr[offset_width_lp+2 +: index_width_lp];
      array_req_o.offset[offset_width_lp-1:0] = tl_req_r.addr[2 +: offset_width_lp];
      array_req_o.data = tl_req_r.data;
    end else begin
      array_req_o.re = v_i & ready_o;
      array_req_o.index[index_width_lp-1:0] = req_i.addr[offset_width_lp+2 +: index_width_lp];
      array_req_o.offset[offset_width_lp-1:0] = req_i.addr[2 +: offset_width_lp];
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
      v_v_r <= 1'b0;
      v_miss_r <= 1'b0;
      miss_start_r <= 1'b0;
      hit_update_r <= 1'b0;
      replay_r <= 1'b0;
    end else begin
      if (ready_o) begin
        tl_v_r <= v_i;
      end else if (tl_moves) begin
        tl_v_r <= 1'b0;
      end
      if (tl_moves) begin
        v_v_r <= 1'b1;
        v_miss_r <= ~tl_hit;
      end else if (v_o && yumi_i) begin
        v_v_r <= 1'b0;
      end
      if (miss_done_i) begin
        v_miss_r <= 1'b0;
      end
      miss_start_r <= tl_moves & ~tl_hit;
      hit_update_r <= tl_moves & tl_hit;
      replay_r <= miss_done_i;
    end
  end

  always_ff @(posedge clock_i) begin
    tl_tags_r <= tl_tags;
    tl_words_r <= tl_words;
    if (v_i && ready_o) begin
      tl_req_r <= req_i;
    end
    if (tl_moves) begin
      v_write_r <= tl_req_r.write;
      v_addr_r <= tl_req_r.addr;
      v_wdata_r <= tl_req_r.data;
      v_way_r <= tl_way;
      v_data_r <= tl_req_r.write ? '0 : tl_words[tl_way];
    end else if (miss_done_i) begin
      v_data_r <= v_write_r ? '0 : fill_word_i;
    end
  end

  assign data_o = v_data_r;

  assign miss_start_o = miss_start_r;
  assign miss_addr_o = v_addr_r;
  assign miss_store_o = v_write_r;
  assign miss_wdata_o = v_wdata_r;

  // replacement state follows the item as it enters v
  assign hit_update_o = hit_update_r;
  assign hit_way_o = v_way_r;
  assign hit_store_o = v_write_r;

endmodule

`default_nettype wire

// File: hdl/cache_repl_state.sv
// Replacement state: one MRU bit and one dirty bit per way for each set.
// Chooses the victim way and reports whether it must be written back.
`timescale 1ns/1ps
`default_nettype none

module cache_repl_state
  import cache_pkg::*;
#(
  parameter int sets_p = 16,
  localparam int index_width_lp = $clog2(sets_p)
) (
  input  wire logic                      clock_i,
  input  wire logic                      reset_i,
  input  wire logic [index_width_lp-1:0] set_i,
  input  wire logic                      hit_update_i,
  input  wire logic                      hit_way_i,
  input  wire logic                      hit_store_i,
  input  wire logic                      fill_update_i,
  input  wire logic                      fill_way_i,
  input  wire logic                      fill_dirty_i,
  output logic                           victim_way_o,
  output logic                           victim_dirty_o
);

  logic [sets_p-1:0] mru_r;
  logic [sets_p-1:0][ways_c-1:0] dirty_r;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      mru_r <= '0;
      dirty_r <= '0;
    end else if (fill_update_i) begin
      mru_r[set_i] <= fill_way_i;
      dirty_r[set_i][fill_way_i] <= fill_dirty_i;
    end else if (hit_update_i) begin
      mru_r[set_i] <= hit_way_i;
      if (hit_store_i) begin
        dirty_r[set_i][hit_way_i] <= 1'b1;
      end
    end
  end

  assign victim_way_o = ~mru_r[set_i];
  assign victim_dirty_o = dirty_r[set_i][victim_way_o];

endmodule

`default_nettype wire

// File: hdl/cache_array_arbiter.sv
// Shares the tag and data arrays between the pipeline and the miss unit.
// The miss unit wins whenever it asks; the owner of returned read data
// is tracked one cycle behind the access.
`timescale 1ns/1ps
`default_nettype none

module cache_array_arbiter
  import cache_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int block_size_in_words_p = 4,
  localparam int index_width_lp = $clog2(sets_p),
  localparam int offset_width_lp = $clog2(block_size_in_words_p)
) (
  input  wire logic                                     clock_i,
  input  wire logic                                     reset_i,
  input  wire array_req_t                               pipe_req_i,
  input  wire array_req_t                               miss_req_i,
  output logic                                          tag_en_o,
  output logic [ways_c-1:0]                             tag_we_o,
  output logic [index_width_lp-1:0]                     tag_addr_o,
  output tag_entry_t                                    tag_wdata_o,
  output logic                                          data_en_o,
  output logic [ways_c-1:0]                             data_we_o,
  output logic [index_width_lp+offset_width_lp-1:0]     data_addr_o,
  output logic [word_width_c-1:0]                       data_wdata_o,
  output logic                                          pipe_owns_rdata_o
);

  logic miss_active;
  array_req_t sel;

  assign miss_active = miss_req_i.re | (|miss_req_i.tag_we) | (|miss_req_i.data_we);
  assign sel = miss_active ? miss_req_i : pipe_req_i;

  assign tag_en_o = sel.re | (|sel.tag_we);
  assign tag_we_o = sel.tag_we;
  assign tag_addr_o = sel.index[index_width_lp-1:0];
  assign tag_wdata_o = sel.tag;

  assign data_en_o = sel.re | (|sel.data_we);
  assign data_we_o = sel.data_we;
  assign data_addr_o = {sel.index[index_width_lp-1:0], sel.offset[offset_width_lp-1:0]};
  assign data_wdata_o = sel.data;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pipe_owns_rdata_o <= 1'b0;
    end else begin
      pipe_owns_rdata_o <= pipe_req_i.re & ~miss_active;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cache_way_ram.sv
// Synchronous single-port RAM holding one entry per way in each row.
// Used for both the tag array and the data array of the cache.
`timescale 1ns/1ps
`default_nettype none

module cache_way_ram
  import cache_pkg::*;
#(
  parameter type entry_t = logic [word_width_c-1:0],
  parameter int depth_p = 16
) (
  input  wire logic                       clock_i,
  input  wire logic                       en_i,
  input  wire logic [ways_c-1:0]          we_i,
  input  wire logic [$clog2(depth_p)-1:0] addr_i,
  input  wire entry_t                     wdata_i,
  output entry_t [ways_c-1:0]             rdata_o
);

  entry_t [ways_c-1:0] mem [depth_p];

  // read returns the row as it was before this cycle's write
  always_ff @(posedge clock_i) begin
    if (en_i) begin
      for (int w = 0; w < ways_c; w++) begin
        if (we_i[w]) begin
          mem[addr_i][w] <= wdata_i;
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
// Shared types and constants for the two-way write-back data cache.
// Every cache module imports this package in its header.
`default_nettype none

package cache_pkg;

  localparam int addr_width_c = 32;
  localparam int word_width_c = 32;
  localparam int ways_c = 2;

  // array request fields are sized for the largest supported cache
  localparam int max_index_width_c = 10;
  localparam int max_offset_width_c = 4;

  typedef struct packed {
    logic write;
    logic [addr_width_c-1:0] addr;
    logic [word_width_c-1:0] data;
  } cache_req_t;

  typedef struct packed {
    logic write_not_read;
    logic [addr_width_c-1:0] addr;
  } dma_req_t;

  // tag is a word address with index and offset bits held at zero
  typedef struct packed {
    logic valid;
    logic [addr_width_c-3:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic re;
    logic [ways_c-1:0] tag_we;
    logic [ways_c-1:0] data_we;
    logic [max_index_width_c-1:0] index;
    logic [max_offset_width_c-1:0] offset;
    tag_entry_t tag;
    logic [word_width_c-1:0] data;
  } array_req_t;

  // word address of addr with the low index and offset bits cleared
  function automatic logic [addr_width_c-3:0] tag_bits(input logic [addr_width_c-1:0] addr,
                                                      input int low_bits);
    logic [addr_width_c-3:0] mask;
    mask = '1;
    mask = mask << low_bits;
    return addr[addr_width_c-1:2] & mask;
  endfunction

endpackage

`default_nettype wire
